// ==== Bender.yml ====
package:
  name: dvs_hssl

sources:
  # RTL in compile order
  - verilog/hssl_pkg.sv
  - verilog/pkt_assembler.sv
  - verilog/pkt_router.sv
  - verilog/hssl_reg_bank.sv
  - verilog/dvs_hssl_top.sv

  # testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_dvs_hssl.sv

// ==== tb.f ====
+incdir+verification
verilog/hssl_pkg.sv
verilog/pkt_assembler.sv
verilog/pkt_router.sv
verilog/hssl_reg_bank.sv
verilog/dvs_hssl_top.sv
verification/tb_dvs_hssl.sv

// ==== verification/tb_tasks.svh ====
// ------------------------------
// testbench tasks and model
// ------------------------------

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// cycles any single wait may take
localparam int TIMEOUT = 200;

// reference copy of the routing table
route_entry_t model_tbl [NUM_ENTRIES];
int unsigned  drop_expect = 0;
int unsigned  err_value   = 0;
int unsigned  err_timeout = 0;

// ------------------------------
// checks and model
// ------------------------------
function automatic void compare_value(input string name, input logic [63:0] exp,
                                      input logic [63:0] act);
  assert (act === exp)
  else
  begin
    $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    err_value++;
  end
endfunction

function automatic void report_timeout(input string what);
  $display("timeout at %0t ns: %s did not happen within %0d cycles", $time, what, TIMEOUT);
  err_timeout++;
endfunction

// first matching entry from index 0 up, -1 when nothing matches
function automatic int model_route(input logic [KEY_BITS-1:0] key);
  for (int i = 0; i < NUM_ENTRIES; i++)
  begin
    if ((key & model_tbl[i].mask) == model_tbl[i].key)
      return int'(model_tbl[i].route);
  end
  return -1;
endfunction

// random key whose model route is want
task automatic pick_key(input int want, output logic [KEY_BITS-1:0] key);
  int tries;
  tries = 0;
  key   = $urandom();
  while (model_route(key) != want && tries < 1000)
  begin
    key = $urandom();
    tries++;
  end
  if (model_route(key) != want)
  begin
    $display("no random key found for route %0d", want);
    err_value++;
  end
endtask

// ------------------------------
// APB
// ------------------------------
task automatic apb_access(input logic write, input logic [7:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
  int n;
  // setup cycle
  @(posedge pl_clk0_buf_int);
  #2;
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = write;
  apb_req.paddr   = addr;
  apb_req.pwdata  = wdata;
  // access cycle
  @(posedge pl_clk0_buf_int);
  #2;
  apb_req.penable = 1'b1;
  n = 0;
  @(negedge pl_clk0_buf_int);
  while (!apb_rsp.pready && n < TIMEOUT)
  begin
    @(negedge pl_clk0_buf_int);
    n++;
  end
  if (n == TIMEOUT)
    report_timeout("pready");
  rdata  = apb_rsp.prdata;
  slverr = apb_rsp.pslverr;
  @(posedge pl_clk0_buf_int);
  #2;
  apb_req = '0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                         input logic exp_err);
  logic [31:0] rd;
  logic        err;
  apb_access(1'b1, addr, data, rd, err);
  compare_value($sformatf("pslverr wr 0x%02h", addr), exp_err, err);
endtask

task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp,
                              input logic exp_err);
  logic [31:0] rd;
  logic        err;
  apb_access(1'b0, addr, 32'h0, rd, err);
  compare_value($sformatf("pslverr rd 0x%02h", addr), exp_err, err);
  if (!exp_err)
    compare_value($sformatf("prdata 0x%02h", addr), exp, rd);
endtask

// upper route bits random, the bank keeps only 3
task automatic set_entry(input int idx, input logic [31:0] key, input logic [31:0] mask,
                         input logic [ROUTE_BITS-1:0] route);
  logic [7:0] offs;
  offs = 8'(idx * 4);
  apb_write(KEY_BASE + offs, key, 1'b0);
  apb_write(MASK_BASE + offs, mask, 1'b0);
  apb_write(ROUTE_BASE + offs, ($urandom() & ~32'h7) | 32'(route), 1'b0);
  model_tbl[idx].key   = key;
  model_tbl[idx].mask  = mask;
  model_tbl[idx].route = route;
endtask

// ------------------------------
// events and channels
// ------------------------------
task automatic send_event(input logic [31:0] data, output int acc_cycle);
  int n;
  @(posedge pl_clk0_buf_int);
  #2;
  evt_data = data;
  evt_vld  = 1'b1;
  n = 0;
  @(negedge pl_clk0_buf_int);
  while (!evt_rdy && n < TIMEOUT)
  begin
    @(negedge pl_clk0_buf_int);
    n++;
  end
  if (n == TIMEOUT)
    report_timeout("event acceptance");
  // accepted on this edge
  @(posedge pl_clk0_buf_int);
  #2;
  acc_cycle = cycle;
  evt_vld   = 1'b0;
endtask

// wait for a delivery, check it, let it drain
task automatic expect_packet(input logic [31:0] key, input int ch, input int acc_cycle,
                             input logic check_lat);
  int n;
  n = 0;
  @(negedge pl_clk0_buf_int);
  while (ch_vld == '0 && n < TIMEOUT)
  begin
    @(negedge pl_clk0_buf_int);
    n++;
  end
  if (n == TIMEOUT)
  begin
    report_timeout($sformatf("packet on channel %0d", ch));
    return;
  end
  compare_value("ch_vld", 64'(1) << ch, ch_vld);
  compare_value($sformatf("ch_pkt[%0d].key", ch), key, ch_pkt[ch].key);
  compare_value("hdr[7:6]", 0, ch_pkt[ch].hdr[7:6]);
  // odd number of ones over all 40 bits
  compare_value("packet parity", 1, ^ch_pkt[ch]);
  // with ch_rdy high the transfer is on the next edge
  if (check_lat)
    compare_value("latency cycles", 2, cycle + 1 - acc_cycle);
  @(posedge pl_clk0_buf_int);
endtask

task automatic expect_quiet(input int cycles);
  repeat (cycles)
  begin
    @(negedge pl_clk0_buf_int);
    compare_value("ch_vld", 0, ch_vld);
  end
endtask

// model decides between delivery and drop
task automatic send_and_check(input logic [31:0] key, input logic check_lat);
  int ch;
  int acc;
  ch = model_route(key);
  send_event(key, acc);
  if (ch < 0)
  begin
    drop_expect++;
    expect_quiet(4);
  end
  else
    expect_packet(key, ch, acc, check_lat);
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic test_registers();
  logic [31:0] k;
  logic [31:0] m;
  apb_read_check(DROP_ADDR, 32'h0, 1'b0);
  apb_read_check(CTRL_ADDR, 32'h0, 1'b0);
  for (int i = 0; i < NUM_ENTRIES; i += 5)
  begin
    k = $urandom();
    m = $urandom();
    set_entry(i, k, m, ROUTE_BITS'(i % NUM_CHANNELS));
    apb_read_check(KEY_BASE + 8'(i * 4), k, 1'b0);
    apb_read_check(MASK_BASE + 8'(i * 4), m, 1'b0);
    apb_read_check(ROUTE_BASE + 8'(i * 4), 32'(i % NUM_CHANNELS), 1'b0);
  end
  // unmapped address errors, drop counter ignores writes
  apb_write(8'h20, 32'h1, 1'b1);
  apb_read_check(8'h20, 32'h0, 1'b1);
  apb_write(DROP_ADDR, 32'h5, 1'b0);
  apb_read_check(CTRL_ADDR, 32'h0, 1'b0);
  apb_read_check(DROP_ADDR, 32'h0, 1'b0);
  // baseline, exact keys that random events miss
  for (int i = 0; i < NUM_ENTRIES; i++)
    set_entry(i, {16'hDEAD, 16'(i)}, 32'hFFFF_FFFF, 3'd0);
endtask

task automatic test_packet_format();
  set_entry(3, 32'h0000_00A5, 32'h0000_00FF, 3'd5);
  repeat (6)
    send_and_check(($urandom() & 32'hFFFF_FF00) | 32'h0000_00A5, 1'b1);
endtask

task automatic test_priority();
  logic [31:0] key;
  // key 0x12xx hits both, lower index wins
  set_entry(8, 32'h0000_1200, 32'h0000_FF00, 3'd1);
  set_entry(9, 32'h0000_0200, 32'h0000_0F00, 3'd4);
  send_and_check(($urandom() & 32'hFFFF_0000) | 32'h0000_1200, 1'b0);
  send_and_check(($urandom() & 32'hFFFF_0000) | 32'h0000_3200, 1'b0);
  // catch-all entry
  set_entry(15, 32'h0, 32'h0, 3'd7);
  pick_key(7, key);
  send_and_check(key, 1'b0);
  set_entry(15, 32'hDEAD_000F, 32'hFFFF_FFFF, 3'd0);
endtask

task automatic test_drops();
  logic [31:0] key;
  repeat (5)
  begin
    pick_key(-1, key);
    send_and_check(key, 1'b0);
  end
  apb_read_check(DROP_ADDR, drop_expect, 1'b0);
endtask

task automatic test_backpressure_stop();
  logic [31:0] k0;
  logic [31:0] k1;
  logic [31:0] k2;
  pkt_t        held;
  int          acc;
  int          n;
  set_entry(14, 32'h0, 32'h0, 3'd6);
  pick_key(6, k0);
  pick_key(6, k1);
  pick_key(6, k2);
  // channel 6 stalled
  @(posedge pl_clk0_buf_int);
  #2;
  ch_rdy    = '1;
  ch_rdy[6] = 1'b0;
  send_event(k0, acc);
  send_event(k1, acc);
  n = 0;
  @(negedge pl_clk0_buf_int);
  while (evt_rdy && n < TIMEOUT)
  begin
    @(negedge pl_clk0_buf_int);
    n++;
  end
  if (n == TIMEOUT)
    report_timeout("evt_rdy falling");
  held = ch_pkt[6];
  compare_value("ch_pkt[6].key", k0, held.key);
  repeat (6)
  begin
    @(negedge pl_clk0_buf_int);
    compare_value("ch_vld", 64'h40, ch_vld);
    compare_value("ch_pkt[6]", held, ch_pkt[6]);
  end
  // release, all three arrive in order
  fork
    send_event(k2, acc);
    begin
      @(posedge pl_clk0_buf_int);
      #2;
      ch_rdy = '1;
      expect_packet(k0, 6, 0, 1'b0);
      expect_packet(k1, 6, 0, 1'b0);
      expect_packet(k2, 6, 0, 1'b0);
    end
  join
  // stop holds the new event back
  apb_write(CTRL_ADDR, 32'h1, 1'b0);
  apb_read_check(CTRL_ADDR, 32'h1, 1'b0);
  pick_key(6, k0);
  send_event(k0, acc);
  expect_quiet(8);
  apb_write(CTRL_ADDR, 32'h0, 1'b0);
  expect_packet(k0, 6, 0, 1'b0);
endtask

`endif

// ==== verification/tb_dvs_hssl.sv ====
// ------------------------------
// event bridge testbench
// ------------------------------

`timescale 1ns/100ps
module tb_dvs_hssl;

  import hssl_pkg::*;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                    pl_clk0_buf_int;
  logic                    rst_n;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic [KEY_BITS-1:0]     evt_data;
  logic                    evt_vld;
  logic                    evt_rdy;
  pkt_t [NUM_CHANNELS-1:0] ch_pkt;
  logic [NUM_CHANNELS-1:0] ch_vld;
  logic [NUM_CHANNELS-1:0] ch_rdy;

  // rising edge count for latency checks
  int unsigned cycle = 0;

  `include "tb_tasks.svh"

  dvs_hssl_top i_dut (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .ch_pkt          (ch_pkt),
    .ch_vld          (ch_vld),
    .ch_rdy          (ch_rdy)
  );

  // 40 ns clock
  initial
  begin
    pl_clk0_buf_int = 1'b0;
    forever
      #20 pl_clk0_buf_int = ~pl_clk0_buf_int;
  end

  always @(posedge pl_clk0_buf_int)
    cycle <= cycle + 1;

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    void'($urandom(32'h07178fa5));
    rst_n    = 1'b0;
    apb_req  = '0;
    evt_data = '0;
    evt_vld  = 1'b0;
    ch_rdy   = '1;
    repeat (8) @(posedge pl_clk0_buf_int);
    #2;
    rst_n = 1'b1;

    // state right after reset
    @(negedge pl_clk0_buf_int);
    compare_value("ch_vld", 0, ch_vld);
    compare_value("evt_rdy", 1, evt_rdy);
    compare_value("pslverr", 0, apb_rsp.pslverr);

    test_registers();
    test_packet_format();
    test_priority();
    test_drops();
    test_backpressure_stop();

    repeat (4) @(posedge pl_clk0_buf_int);
    $display("errors: %0d value, %0d timeout", err_value, err_timeout);
    if (err_value == 0 && err_timeout == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog/dvs_hssl_top.sv ====
// ------------------------------
// event bridge top level
// ------------------------------

`timescale 1ns/100ps
module dvs_hssl_top (
  input  logic                                        pl_clk0_buf_int,
  input  logic                                        rst_n,
  // APB configuration port
  input  hssl_pkg::apb_req_t                          apb_req,
  output hssl_pkg::apb_rsp_t                          apb_rsp,
  // event input
  input  logic [hssl_pkg::KEY_BITS-1:0]               evt_data,
  input  logic                                        evt_vld,
  output logic                                        evt_rdy,
  // channel outputs
  output hssl_pkg::pkt_t [hssl_pkg::NUM_CHANNELS-1:0] ch_pkt,
  output logic [hssl_pkg::NUM_CHANNELS-1:0]           ch_vld,
  input  logic [hssl_pkg::NUM_CHANNELS-1:0]           ch_rdy
);

  import hssl_pkg::*;

  // ------------------------------
  // internal signals
  // ------------------------------
  // bank to router
  route_entry_t [NUM_ENTRIES-1:0] route_table;
  logic                           stop;
  // router to bank
  logic [CNT_BITS-1:0]            drop_cnt;
  // assembler to router
  pkt_t                           pkt;
  logic                           pkt_vld;
  logic                           pkt_rdy;

  // table, stop bit and counter read-back
  hssl_reg_bank u_reg_bank (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .drop_cnt        (drop_cnt),
    .route_table     (route_table),
    .stop            (stop)
  );

  // events in, packets out
  pkt_assembler u_assembler (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .pkt             (pkt),
    .pkt_vld         (pkt_vld),
    .pkt_rdy         (pkt_rdy)
  );

  // lookup and channel delivery
  pkt_router u_router (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .pkt             (pkt),
    .pkt_vld         (pkt_vld),
    .pkt_rdy         (pkt_rdy),
    .route_table     (route_table),
    .stop            (stop),
    .ch_pkt          (ch_pkt),
    .ch_vld          (ch_vld),
    .ch_rdy          (ch_rdy),
    .drop_cnt        (drop_cnt)
  );

endmodule

// ==== verilog/hssl_pkg.sv ====
// ------------------------------
// event bridge shared types
// ------------------------------

package hssl_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int NUM_CHANNELS  = 8;
  localparam int NUM_ENTRIES   = 16;
  localparam int KEY_BITS      = 32;
  localparam int HDR_BITS      = 8;
  localparam int ROUTE_BITS    = 3;
  localparam int CNT_BITS      = 16;
  localparam int APB_ADDR_BITS = 8;
  localparam int APB_DATA_BITS = 32;
  // table entry index taken from paddr[5:2]
  localparam int IDX_BITS      = $clog2(NUM_ENTRIES);

  // multicast header before parity, all type bits clear
  localparam logic [HDR_BITS-1:0] HDR_MC_TYPE = 8'h00;

  // ------------------------------
  // address map
  // ------------------------------
  localparam logic [APB_ADDR_BITS-1:0] CTRL_ADDR  = 8'h00;
  localparam logic [APB_ADDR_BITS-1:0] DROP_ADDR  = 8'h04;
  localparam logic [APB_ADDR_BITS-1:0] KEY_BASE   = 8'h40;
  localparam logic [APB_ADDR_BITS-1:0] MASK_BASE  = 8'h80;
  localparam logic [APB_ADDR_BITS-1:0] ROUTE_BASE = 8'hC0;

  // decoded address regions
  typedef enum logic [2:0] {
    REG_CTRL,
    REG_DROP,
    REG_KEY,
    REG_MASK,
    REG_ROUTE,
    REG_NONE
  } reg_region_e;

  // ------------------------------
  // structs
  // ------------------------------
  // header in the top byte, bit 0 of hdr is the parity bit
  typedef struct packed {
    logic [HDR_BITS-1:0] hdr;
    logic [KEY_BITS-1:0] key;
  } pkt_t;

  // one routing table entry
  typedef struct packed {
    logic [KEY_BITS-1:0]   key;
    logic [KEY_BITS-1:0]   mask;
    logic [ROUTE_BITS-1:0] route;
  } route_entry_t;

  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
  } apb_rsp_t;

endpackage

// ==== verilog/hssl_reg_bank.sv ====
// ------------------------------
// APB register bank
// ------------------------------

`timescale 1ns/100ps
module hssl_reg_bank (
  input  logic                                              pl_clk0_buf_int,
  input  logic                                              rst_n,
  // APB slave port
  input  hssl_pkg::apb_req_t                                apb_req,
  output hssl_pkg::apb_rsp_t                                apb_rsp,
  // status from the router
  input  logic [hssl_pkg::CNT_BITS-1:0]                     drop_cnt,
  // configuration towards the router
  output hssl_pkg::route_entry_t [hssl_pkg::NUM_ENTRIES-1:0] route_table,
  output logic                                              stop
);

  import hssl_pkg::*;

  reg_region_e             region;
  logic [IDX_BITS-1:0]     idx;
  logic                    access;
  logic                    wr_en;
  logic [APB_DATA_BITS-1:0] rd_data;

  // ------------------------------
  // address decode
  // ------------------------------
  // word entries at 4-byte steps, index from paddr[5:2]
  assign idx = apb_req.paddr[IDX_BITS+1:2];

  always_comb
  begin
    region = REG_NONE;
    if (apb_req.paddr == CTRL_ADDR)
      region = REG_CTRL;
    else if (apb_req.paddr == DROP_ADDR)
      region = REG_DROP;
    else if (apb_req.paddr[1:0] == 2'b00)
    begin
      // table regions by the top two address bits
      if (apb_req.paddr[7:6] == KEY_BASE[7:6])
        region = REG_KEY;
      else if (apb_req.paddr[7:6] == MASK_BASE[7:6])
        region = REG_MASK;
      else if (apb_req.paddr[7:6] == ROUTE_BASE[7:6])
        region = REG_ROUTE;
    end
  end

  // access phase of the transfer
  assign access = apb_req.psel && apb_req.penable;
  // unmapped addresses never write
  assign wr_en  = access && apb_req.pwrite && (region != REG_NONE);

  // ------------------------------
  // register writes
  // ------------------------------
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
    begin
      route_table <= '0;
      stop        <= 1'b0;
    end
    else if (wr_en)
    begin
      case (region)
        REG_CTRL:
          stop <= apb_req.pwdata[0];
        REG_KEY:
          route_table[idx].key <= apb_req.pwdata;
        REG_MASK:
          route_table[idx].mask <= apb_req.pwdata;
        REG_ROUTE:
          route_table[idx].route <= apb_req.pwdata[ROUTE_BITS-1:0];
        // drop counter is read-only
        default:
          ;
      endcase
    end
  end

  // ------------------------------
  // read back and response
  // ------------------------------
  always_comb
  begin
    case (region)
      REG_CTRL:
        rd_data = {{(APB_DATA_BITS-1){1'b0}}, stop};
      REG_DROP:
        rd_data = {{(APB_DATA_BITS-CNT_BITS){1'b0}}, drop_cnt};
      REG_KEY:
        rd_data = route_table[idx].key;
      REG_MASK:
        rd_data = route_table[idx].mask;
      REG_ROUTE:
        // route zero-extended to the bus width
        rd_data = {{(APB_DATA_BITS-ROUTE_BITS){1'b0}}, route_table[idx].route};
      default:
        rd_data = '0;
    endcase
  end

  // no wait states
  always_comb
  begin
    apb_rsp.prdata  = rd_data;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && (region == REG_NONE);
  end

endmodule

// ==== verilog/pkt_assembler.sv ====
// ------------------------------
// event to packet assembler
// ------------------------------

`timescale 1ns/100ps
module pkt_assembler (
  input  logic                         pl_clk0_buf_int,
  input  logic                         rst_n,
  // incoming event
  input  logic [hssl_pkg::KEY_BITS-1:0] evt_data,
  input  logic                         evt_vld,
  output logic                         evt_rdy,
  // assembled packet towards the router
  output hssl_pkg::pkt_t               pkt,
  output logic                         pkt_vld,
  input  logic                         pkt_rdy
);

  import hssl_pkg::*;

  logic evt_acc;

  // free slot, or the current packet leaves this cycle
  assign evt_rdy = !pkt_vld || pkt_rdy;
  assign evt_acc = evt_vld && evt_rdy;

  // output register valid flag
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
      pkt_vld <= 1'b0;
    else if (evt_acc)
      pkt_vld <= 1'b1;
    else if (pkt_rdy)
      pkt_vld <= 1'b0;
  end

  // packet contents, held steady while stalled
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_acc)
    begin
      pkt.key <= evt_data;
      // type bits from the mc header, bit 0 makes total ones odd
      pkt.hdr <= {HDR_MC_TYPE[HDR_BITS-1:1], ~^{HDR_MC_TYPE[HDR_BITS-1:1], evt_data}};
    end
  end

endmodule

// ==== verilog/pkt_router.sv ====
// ------------------------------
// multicast packet router
// ------------------------------

`timescale 1ns/100ps
module pkt_router (
  input  logic                                              pl_clk0_buf_int,
  input  logic                                              rst_n,
  // assembled packet
  input  hssl_pkg::pkt_t                                    pkt,
  input  logic                                              pkt_vld,
  output logic                                              pkt_rdy,
  // routing table and control from the register bank
  input  hssl_pkg::route_entry_t [hssl_pkg::NUM_ENTRIES-1:0] route_table,
  input  logic                                              stop,
  // channel outputs
  output hssl_pkg::pkt_t [hssl_pkg::NUM_CHANNELS-1:0]       ch_pkt,
  output logic [hssl_pkg::NUM_CHANNELS-1:0]                 ch_vld,
  input  logic [hssl_pkg::NUM_CHANNELS-1:0]                 ch_rdy,
  // unmatched packet count
  output logic [hssl_pkg::CNT_BITS-1:0]                     drop_cnt
);

  import hssl_pkg::*;

  // holding register
  pkt_t                  hold_pkt;
  logic                  hold_vld;
  logic [ROUTE_BITS-1:0] hold_route;

  // lookup result for the incoming packet
  logic                  hit;
  logic [ROUTE_BITS-1:0] hit_route;

  logic hold_drain;
  logic pkt_acc;

  // ------------------------------
  // table lookup
  // ------------------------------
  // scan downwards so the lowest matching index is the last to win
  always_comb
  begin
    hit       = 1'b0;
    hit_route = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--)
    begin
      if ((pkt.key & route_table[i].mask) == route_table[i].key)
      begin
        hit       = 1'b1;
        hit_route = route_table[i].route;
      end
    end
  end

  // ------------------------------
  // flow control
  // ------------------------------
  // held packet taken by its channel this cycle
  assign hold_drain = hold_vld && ch_rdy[hold_route];
  // stop only blocks new packets, the held one still drains
  assign pkt_rdy    = !stop && (!hold_vld || hold_drain);
  assign pkt_acc    = pkt_vld && pkt_rdy;

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
    begin
      hold_vld   <= 1'b0;
      hold_route <= '0;
      drop_cnt   <= '0;
    end
    else if (pkt_acc)
    begin
      // slot is free or draining, so a miss leaves it empty
      hold_vld <= hit;
      if (hit)
        hold_route <= hit_route;
      else
        drop_cnt <= drop_cnt + 1'b1;
    end
    else if (hold_drain)
      hold_vld <= 1'b0;
  end

  // packet payload
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (pkt_acc && hit)
      hold_pkt <= pkt;
  end

  // ------------------------------
  // channel outputs
  // ------------------------------
  // same packet on every lane, valid only on the routed one
  always_comb
  begin
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      ch_pkt[c] = hold_pkt;
      ch_vld[c] = hold_vld && (hold_route == ROUTE_BITS'(c));
    end
  end

endmodule
